//--- build.f
logic/ht_pkg.sv
logic/ht_issue.sv
logic/ht_bucket_ram.sv
logic/ht_match.sv
logic/ht_update.sv
logic/ht_queue.sv
logic/ht_engine.sv
test/tb_clock.sv
test/tb_ht_engine.sv

//--- test/tb_ht_engine.sv
// testbench for the hash table engine, reference table model and in-order compare
`default_nettype none

module tb_ht_engine;
	import ht_pkg::*;

	logic clk;
	logic rst_regd;

	logic req_valid = 1'b0;
	opcode_t req_op = OP_GET;
	key_t req_key = '0;
	bucket_addr_t req_hash1 = '0;
	bucket_addr_t req_hash2 = '0;
	ptr_t req_ptr = '0;
	size_t req_size = '0;
	tag_t req_tag = '0;
	logic resp_ready = 1'b1;
	logic free_ready = 1'b1;

	logic req_ready;
	logic resp_valid;
	tag_t resp_tag;
	status_t resp_status;
	ptr_t resp_ptr;
	size_t resp_size;
	logic free_valid;
	ptr_t free_ptr;
	size_t free_size;

	integer seed = 32'h60b8e92b;
	integer ready_seed = 32'h60b8e92b ^ 32'h0f0f0f0f;
	logic random_ready = 1'b0;
	tag_t tag_ctr = '0;

	// reference state, one entry per bucket ever written
	bucket_t table_model [bucket_addr_t];
	resp_t exp_resp [$];
	free_t exp_free [$];

	tb_clock u_tb_clock (
		.clk(clk),
		.rst_regd(rst_regd)
	);

	ht_engine u_ht_engine (
		.clk(clk), .rst_regd(rst_regd),
		.req_valid(req_valid), .req_op(req_op), .req_key(req_key),
		.req_hash1(req_hash1), .req_hash2(req_hash2), .req_ptr(req_ptr),
		.req_size(req_size), .req_tag(req_tag),
		.resp_ready(resp_ready), .free_ready(free_ready),
		.req_ready(req_ready), .resp_valid(resp_valid), .resp_tag(resp_tag),
		.resp_status(resp_status), .resp_ptr(resp_ptr), .resp_size(resp_size),
		.free_valid(free_valid), .free_ptr(free_ptr), .free_size(free_size)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_resp(input status_t exp_status, input status_t got_status,
			input ptr_t exp_ptr, input ptr_t got_ptr, input size_t exp_size,
			input size_t got_size, input tag_t exp_tag, input tag_t got_tag);
		if (got_tag !== exp_tag)
			report_failure($sformatf("error resp_tag expected %h got %h", exp_tag, got_tag));
		if (got_status !== exp_status)
			report_failure($sformatf("error resp_status expected %h got %h",
				exp_status, got_status));
		if (got_ptr !== exp_ptr)
			report_failure($sformatf("error resp_ptr expected %h got %h", exp_ptr, got_ptr));
		if (got_size !== exp_size)
			report_failure($sformatf("error resp_size expected %h got %h", exp_size, got_size));
	endtask

	task automatic check_free(input ptr_t exp_ptr, input ptr_t got_ptr,
			input size_t exp_size, input size_t got_size);
		if (got_ptr !== exp_ptr)
			report_failure($sformatf("error free_ptr expected %h got %h", exp_ptr, got_ptr));
		if (got_size !== exp_size)
			report_failure($sformatf("error free_size expected %h got %h", exp_size, got_size));
	endtask

	// ----------------------------------------------------------------------
	// reference model

	function automatic int find_slot(input bucket_t b, input key_t k);
		for (int s = 0; s < SLOTS; s++) begin
			if (b[s].key == k) begin
				return s;
			end
		end
		return -1;
	endfunction

	function automatic void model_apply(input opcode_t op, input key_t key,
			input bucket_addr_t h1, input bucket_addr_t h2, input ptr_t ptr,
			input size_t size, input tag_t tag);
		bucket_t b1;
		bucket_t b2;
		bucket_t bk;
		bucket_addr_t addr;
		int idx;
		logic hit;
		logic room;
		resp_t r;
		free_t f;
		b1 = table_model.exists(h1) ? table_model[h1] : '0;
		b2 = table_model.exists(h2) ? table_model[h2] : '0;
		hit = 1'b0;
		room = 1'b0;
		addr = h1;
		bk = b1;
		idx = 0;
		// key in hash1, key in hash2, then first empty of hash1, of hash2
		if (find_slot(b1, key) >= 0) begin
			hit = 1'b1;
			idx = find_slot(b1, key);
		end else if (find_slot(b2, key) >= 0) begin
			hit = 1'b1;
			addr = h2;
			bk = b2;
			idx = find_slot(b2, key);
		end else if (find_slot(b1, key_t'(0)) >= 0) begin
			room = 1'b1;
			idx = find_slot(b1, key_t'(0));
		end else if (find_slot(b2, key_t'(0)) >= 0) begin
			room = 1'b1;
			addr = h2;
			bk = b2;
			idx = find_slot(b2, key_t'(0));
		end
		r.tag = tag;
		r.status = ST_MISS;
		r.ptr = '0;
		r.size = '0;
		f.ptr = bk[idx].ptr;
		f.size = bk[idx].size;
		if (op == OP_GET && hit) begin
			r.status = ST_HIT;
			r.ptr = bk[idx].ptr;
			r.size = bk[idx].size;
		end else if (op == OP_SETCUR) begin
			r.ptr = ptr;
			r.size = size;
			if (hit || room) begin
				r.status = hit ? ST_REPLACED : ST_STORED;
				if (hit) begin
					exp_free.push_back(f);
				end
				bk[idx].key = key;
				bk[idx].ptr = ptr;
				bk[idx].size = size;
				table_model[addr] = bk;
			end else begin
				r.status = ST_FULL;
			end
		end else if (op == OP_DELCUR && hit) begin
			r.status = ST_HIT;
			r.ptr = f.ptr;
			r.size = f.size;
			exp_free.push_back(f);
			bk[idx] = '0;
			table_model[addr] = bk;
		end
		exp_resp.push_back(r);
	endfunction

	// small hash space for the random run
	function automatic bucket_addr_t home_bucket(input key_t k);
		return bucket_addr_t'(8'h80 + k % 5);
	endfunction

	function automatic bucket_addr_t alt_bucket(input key_t k);
		return bucket_addr_t'(8'h88 + k % 3);
	endfunction

	// ----------------------------------------------------------------------
	// stimulus helpers, each called on a rising edge

	task automatic send_req(input opcode_t op, input key_t key, input bucket_addr_t h1,
			input bucket_addr_t h2, input ptr_t ptr, input size_t size);
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		req_valid <= 1'b1;
		req_op <= op;
		req_key <= key;
		req_hash1 <= h1;
		req_hash2 <= h2;
		req_ptr <= ptr;
		req_size <= size;
		req_tag <= tag_ctr;
		while (!done) begin
			@(posedge clk);
			if (req_ready) begin
				done = 1'b1;
				model_apply(op, key, h1, h2, ptr, size, tag_ctr);
			end else begin
				waited++;
				if (waited > 200)
					report_failure("request was not accepted within 200 cycles");
			end
		end
		tag_ctr++;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		req_valid <= 1'b0;
		while (exp_resp.size() != 0 || exp_free.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 500)
				report_failure("expected responses or frees never arrived");
		end
	endtask

	// ----------------------------------------------------------------------
	// compare processes

	always @(posedge clk) begin
		resp_t e;
		if (!rst_regd && resp_valid && resp_ready) begin
			if (exp_resp.size() == 0) begin
				report_failure("a response arrived when none was expected");
			end else begin
				e = exp_resp.pop_front();
				check_resp(e.status, resp_status, e.ptr, resp_ptr, e.size, resp_size,
					e.tag, resp_tag);
			end
		end
	end

	always @(posedge clk) begin
		free_t e;
		if (!rst_regd && free_valid && free_ready) begin
			if (exp_free.size() == 0) begin
				report_failure("a free record arrived when none was expected");
			end else begin
				e = exp_free.pop_front();
				check_free(e.ptr, free_ptr, e.size, free_size);
			end
		end
	end

	// output back-pressure
	always @(posedge clk) begin
		if (random_ready) begin
			resp_ready <= ($random(ready_seed) & 3) != 0;
			free_ready <= ($random(ready_seed) & 3) != 0;
		end else begin
			resp_ready <= 1'b1;
			free_ready <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	initial begin
		int waited;
		key_t k;
		int r;
		opcode_t op;
		waited = 0;
		while (rst_regd !== 1'b0) begin
			@(posedge clk);
			waited++;
			if (waited > 20)
				report_failure("reset was never released");
		end

		// test 1, empty table after reset
		if (resp_valid !== 1'b0)
			report_failure($sformatf("error resp_valid expected 0 got %h", resp_valid));
		if (free_valid !== 1'b0)
			report_failure($sformatf("error free_valid expected 0 got %h", free_valid));
		send_req(OP_GET, 64'h1234_5678_9abc_def0, 8'h01, 8'h02, 32'h11, 16'h1);
		send_req(OP_GET, 64'h1, 8'hff, 8'hfe, 32'h22, 16'h2);
		wait_drained();

		// test 2, inserts then lookups, the last pair back to back
		for (int i = 0; i < 4; i++) begin
			send_req(OP_SETCUR, key_t'(64'h1000 + i), bucket_addr_t'(8'h10 + i),
				bucket_addr_t'(8'h20 + i), ptr_t'(32'hA000 + i), size_t'(16'h40 + i));
		end
		for (int i = 0; i < 4; i++) begin
			send_req(OP_GET, key_t'(64'h1000 + i), bucket_addr_t'(8'h10 + i),
				bucket_addr_t'(8'h20 + i), '0, '0);
		end
		send_req(OP_SETCUR, 64'h2000, 8'h30, 8'h31, 32'hB000, 16'h80);
		send_req(OP_GET, 64'h2000, 8'h30, 8'h31, '0, '0);
		wait_drained();

		// test 3, replace frees the old pointer
		send_req(OP_SETCUR, 64'h1001, 8'h11, 8'h21, 32'hC001, 16'h99);
		send_req(OP_GET, 64'h1001, 8'h11, 8'h21, '0, '0);
		wait_drained();

		// test 4, nine keys on one bucket pair
		for (int i = 0; i < 9; i++) begin
			send_req(OP_SETCUR, key_t'(64'h4000 + i), 8'h40, 8'h41,
				ptr_t'(32'hD000 + i), size_t'(16'h10 + i));
		end
		for (int i = 0; i < 9; i++) begin
			send_req(OP_GET, key_t'(64'h4000 + i), 8'h40, 8'h41, '0, '0);
		end
		wait_drained();

		// test 5, delete, miss on delete, reuse of the cleared slot
		send_req(OP_DELCUR, 64'h4002, 8'h40, 8'h41, '0, '0);
		send_req(OP_GET, 64'h4002, 8'h40, 8'h41, '0, '0);
		send_req(OP_DELCUR, 64'h4002, 8'h40, 8'h41, '0, '0);
		send_req(OP_SETCUR, 64'h4008, 8'h40, 8'h41, 32'hE008, 16'h77);
		send_req(OP_GET, 64'h4008, 8'h40, 8'h41, '0, '0);
		wait_drained();

		// test 6, random mix with back-pressure on both output streams
		random_ready <= 1'b1;
		for (int n = 0; n < 300; n++) begin
			k = key_t'(($random(seed) & 32'h1f) + 1);
			r = $random(seed) & 3;
			op = (r == 0) ? OP_GET : (r == 2) ? OP_DELCUR : OP_SETCUR;
			send_req(op, k, home_bucket(k), alt_bucket(k), ptr_t'($random(seed)),
				size_t'($random(seed)));
			if (($random(seed) & 7) == 0) begin
				req_valid <= 1'b0;
				@(posedge clk);
			end
		end
		wait_drained();
		random_ready <= 1'b0;

		// let any stray record show up before the final check
		repeat (8) @(posedge clk);
		if (exp_resp.size() == 0 && exp_free.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			report_failure("expected queues were not empty at the end");
		end
	end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// testbench clock source, period 10, with reset held high for the first two edges
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_regd
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst_regd = 1'b1;
		repeat (2) @(posedge clk);
		rst_regd <= 1'b0;
	end

endmodule

`default_nettype wire

//--- logic/ht_engine.sv
// hash table engine top, issue, RAM, match, update and the two output queues
`default_nettype none

module ht_engine (
	input wire clk,
	input wire rst_regd,
	input wire req_valid,
	input wire ht_pkg::opcode_t req_op,
	input wire ht_pkg::key_t req_key,
	input wire ht_pkg::bucket_addr_t req_hash1,
	input wire ht_pkg::bucket_addr_t req_hash2,
	input wire ht_pkg::ptr_t req_ptr,
	input wire ht_pkg::size_t req_size,
	input wire ht_pkg::tag_t req_tag,
	input wire resp_ready,
	input wire free_ready,
	output logic req_ready,
	output logic resp_valid,
	output ht_pkg::tag_t resp_tag,
	output ht_pkg::status_t resp_status,
	output ht_pkg::ptr_t resp_ptr,
	output ht_pkg::size_t resp_size,
	output logic free_valid,
	output ht_pkg::ptr_t free_ptr,
	output ht_pkg::size_t free_size
);
	import ht_pkg::*;

	logic adv;
	logic rd_en;
	bucket_addr_t rd_addr1;
	bucket_addr_t rd_addr2;
	bucket_t rd_bucket1;
	bucket_t rd_bucket2;
	logic wr_en;
	bucket_addr_t wr_addr;
	bucket_t wr_bucket;

	// issue to match
	logic iss_valid;
	opcode_t iss_op;
	key_t iss_key;
	bucket_addr_t iss_hash1;
	bucket_addr_t iss_hash2;
	ptr_t iss_ptr;
	size_t iss_size;
	tag_t iss_tag;

	// match to update
	logic match_busy;
	bucket_addr_t match_hash1;
	bucket_addr_t match_hash2;
	logic m_valid;
	opcode_t m_op;
	key_t m_key;
	ptr_t m_ptr;
	size_t m_size;
	tag_t m_tag;
	logic m_hit;
	logic m_room;
	bucket_addr_t m_addr;
	slot_idx_t m_idx;
	bucket_t m_bucket;

	// update to queues
	logic upd_busy;
	bucket_addr_t upd_addr;
	logic resp_in_valid;
	logic resp_in_ready;
	resp_t resp_in;
	resp_t resp_out;
	logic free_in_valid;
	logic free_in_ready;
	free_t free_in;
	free_t free_out;

	// ----------------------------------------------------------------------
	ht_issue u_ht_issue (
		.clk(clk), .rst_regd(rst_regd),
		.req_valid(req_valid), .req_op(req_op), .req_key(req_key),
		.req_hash1(req_hash1), .req_hash2(req_hash2), .req_ptr(req_ptr),
		.req_size(req_size), .req_tag(req_tag), .adv(adv),
		.match_busy(match_busy), .match_hash1(match_hash1), .match_hash2(match_hash2),
		.upd_busy(upd_busy), .upd_addr(upd_addr), .req_ready(req_ready),
		.rd_en(rd_en), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.iss_valid(iss_valid), .iss_op(iss_op), .iss_key(iss_key),
		.iss_hash1(iss_hash1), .iss_hash2(iss_hash2), .iss_ptr(iss_ptr),
		.iss_size(iss_size), .iss_tag(iss_tag)
	);

	ht_bucket_ram u_ht_bucket_ram (
		.clk(clk), .rst_regd(rst_regd),
		.rd_en(rd_en), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_bucket(wr_bucket),
		.rd_bucket1(rd_bucket1), .rd_bucket2(rd_bucket2)
	);

	ht_match u_ht_match (
		.clk(clk), .rst_regd(rst_regd), .adv(adv),
		.iss_valid(iss_valid), .iss_op(iss_op), .iss_key(iss_key),
		.iss_hash1(iss_hash1), .iss_hash2(iss_hash2), .iss_ptr(iss_ptr),
		.iss_size(iss_size), .iss_tag(iss_tag),
		.rd_bucket1(rd_bucket1), .rd_bucket2(rd_bucket2),
		.match_busy(match_busy), .match_hash1(match_hash1), .match_hash2(match_hash2),
		.m_valid(m_valid), .m_op(m_op), .m_key(m_key), .m_ptr(m_ptr),
		.m_size(m_size), .m_tag(m_tag), .m_hit(m_hit), .m_room(m_room),
		.m_addr(m_addr), .m_idx(m_idx), .m_bucket(m_bucket)
	);

	ht_update u_ht_update (
		.clk(clk), .rst_regd(rst_regd),
		.m_valid(m_valid), .m_op(m_op), .m_key(m_key), .m_ptr(m_ptr),
		.m_size(m_size), .m_tag(m_tag), .m_hit(m_hit), .m_room(m_room),
		.m_addr(m_addr), .m_idx(m_idx), .m_bucket(m_bucket),
		.resp_in_ready(resp_in_ready), .free_in_ready(free_in_ready),
		.adv(adv), .upd_busy(upd_busy), .upd_addr(upd_addr),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_bucket(wr_bucket),
		.resp_in_valid(resp_in_valid), .resp_in(resp_in),
		.free_in_valid(free_in_valid), .free_in(free_in)
	);

	ht_queue #(.payload_t(resp_t), .DEPTH(RESP_DEPTH)) u_resp_queue (
		.clk(clk), .rst_regd(rst_regd),
		.in_valid(resp_in_valid), .in_data(resp_in), .out_ready(resp_ready),
		.in_ready(resp_in_ready), .out_valid(resp_valid), .out_data(resp_out)
	);

	ht_queue #(.payload_t(free_t), .DEPTH(FREE_DEPTH)) u_free_queue (
		.clk(clk), .rst_regd(rst_regd),
		.in_valid(free_in_valid), .in_data(free_in), .out_ready(free_ready),
		.in_ready(free_in_ready), .out_valid(free_valid), .out_data(free_out)
	);

	assign resp_tag = resp_out.tag;
	assign resp_status = resp_out.status;
	assign resp_ptr = resp_out.ptr;
	assign resp_size = resp_out.size;
	assign free_ptr = free_out.ptr;
	assign free_size = free_out.size;

endmodule

`default_nettype wire

//--- logic/ht_queue.sv
// small circular valid/ready FIFO for response and free records
`default_nettype none

module ht_queue #(
	parameter type payload_t = ht_pkg::resp_t,
	parameter int DEPTH = 4
) (
	input wire clk,
	input wire rst_regd,
	input wire in_valid,
	input wire payload_t in_data,
	input wire out_ready,
	output logic in_ready,
	output logic out_valid,
	output payload_t out_data
);
	typedef logic [$clog2(DEPTH)-1:0] qptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] qcnt_t;

	payload_t mem [DEPTH];
	qptr_t head;
	qptr_t tail;
	qcnt_t count;
	logic push;
	logic pop;

	assign in_ready = count != qcnt_t'(DEPTH);
	assign out_valid = count != '0;
	assign out_data = mem[head];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= (tail == qptr_t'(DEPTH - 1)) ? '0 : tail + 1'b1;
			end
			if (pop) begin
				head <= (head == qptr_t'(DEPTH - 1)) ? '0 : head + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[tail] <= in_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/ht_update.sv
// update stage that applies the operation, writes the bucket back and pushes records
`default_nettype none

module ht_update (
	input wire clk,
	input wire rst_regd,
	input wire m_valid,
	input wire ht_pkg::opcode_t m_op,
	input wire ht_pkg::key_t m_key,
	input wire ht_pkg::ptr_t m_ptr,
	input wire ht_pkg::size_t m_size,
	input wire ht_pkg::tag_t m_tag,
	input wire m_hit,
	input wire m_room,
	input wire ht_pkg::bucket_addr_t m_addr,
	input wire ht_pkg::slot_idx_t m_idx,
	input wire ht_pkg::bucket_t m_bucket,
	input wire resp_in_ready,
	input wire free_in_ready,
	output logic adv,
	output logic upd_busy,
	output ht_pkg::bucket_addr_t upd_addr,
	output logic wr_en,
	output ht_pkg::bucket_addr_t wr_addr,
	output ht_pkg::bucket_t wr_bucket,
	output logic resp_in_valid,
	output ht_pkg::resp_t resp_in,
	output logic free_in_valid,
	output ht_pkg::free_t free_in
);
	import ht_pkg::*;

	logic u_valid;
	opcode_t u_op;
	key_t u_key;
	ptr_t u_ptr;
	size_t u_size;
	tag_t u_tag;
	logic u_hit;
	logic u_room;
	bucket_addr_t u_addr;
	slot_idx_t u_idx;
	bucket_t u_bucket;
	slot_t old_slot;
	slot_t new_slot;
	logic changes;
	logic frees;
	logic fire;

	// whole pipeline moves only when this stage can retire
	assign adv = !u_valid || (resp_in_ready && free_in_ready);
	assign fire = u_valid && resp_in_ready && free_in_ready;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			u_valid <= 1'b0;
		end else if (adv) begin
			u_valid <= m_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (adv && m_valid) begin
			u_op <= m_op;
			u_key <= m_key;
			u_ptr <= m_ptr;
			u_size <= m_size;
			u_tag <= m_tag;
			u_hit <= m_hit;
			u_room <= m_room;
			u_addr <= m_addr;
			u_idx <= m_idx;
			u_bucket <= m_bucket;
		end
	end

	// ----------------------------------------------------------------------
	// operation rules
	always_comb begin
		old_slot = u_bucket[u_idx];
		new_slot = old_slot;
		changes = 1'b0;
		frees = 1'b0;
		resp_in.tag = u_tag;
		resp_in.status = ST_MISS;
		resp_in.ptr = '0;
		resp_in.size = '0;
		case (u_op)
			OP_SETCUR: begin
				resp_in.ptr = u_ptr;
				resp_in.size = u_size;
				new_slot.key = u_key;
				new_slot.ptr = u_ptr;
				new_slot.size = u_size;
				if (u_hit) begin
					resp_in.status = ST_REPLACED;
					changes = 1'b1;
					frees = 1'b1;
				end else if (u_room) begin
					resp_in.status = ST_STORED;
					changes = 1'b1;
				end else begin
					resp_in.status = ST_FULL;
				end
			end
			OP_DELCUR: begin
				if (u_hit) begin
					new_slot = '0;
					changes = 1'b1;
					frees = 1'b1;
					resp_in.status = ST_HIT;
					resp_in.ptr = old_slot.ptr;
					resp_in.size = old_slot.size;
				end
			end
			default: begin
				if (u_hit) begin
					resp_in.status = ST_HIT;
					resp_in.ptr = old_slot.ptr;
					resp_in.size = old_slot.size;
				end
			end
		endcase
	end

	always_comb begin
		wr_bucket = u_bucket;
		wr_bucket[u_idx] = new_slot;
	end

	assign wr_en = fire && changes;
	assign wr_addr = u_addr;
	assign resp_in_valid = fire;
	assign free_in_valid = fire && frees;
	assign free_in.ptr = old_slot.ptr;
	assign free_in.size = old_slot.size;
	assign upd_busy = u_valid;
	assign upd_addr = u_addr;

	// a released pointer always comes from the slot that holds the key
	a_free_on_hit: assert property (@(posedge clk) disable iff (rst_regd)
		free_in_valid |-> old_slot.key == u_key && old_slot.key != '0);

endmodule

`default_nettype wire

//--- logic/ht_match.sv
// match stage that finds a key hit or a free slot across both candidate buckets
`default_nettype none

module ht_match (
	input wire clk,
	input wire rst_regd,
	input wire adv,
	input wire iss_valid,
	input wire ht_pkg::opcode_t iss_op,
	input wire ht_pkg::key_t iss_key,
	input wire ht_pkg::bucket_addr_t iss_hash1,
	input wire ht_pkg::bucket_addr_t iss_hash2,
	input wire ht_pkg::ptr_t iss_ptr,
	input wire ht_pkg::size_t iss_size,
	input wire ht_pkg::tag_t iss_tag,
	input wire ht_pkg::bucket_t rd_bucket1,
	input wire ht_pkg::bucket_t rd_bucket2,
	output logic match_busy,
	output ht_pkg::bucket_addr_t match_hash1,
	output ht_pkg::bucket_addr_t match_hash2,
	output logic m_valid,
	output ht_pkg::opcode_t m_op,
	output ht_pkg::key_t m_key,
	output ht_pkg::ptr_t m_ptr,
	output ht_pkg::size_t m_size,
	output ht_pkg::tag_t m_tag,
	output logic m_hit,
	output logic m_room,
	output ht_pkg::bucket_addr_t m_addr,
	output ht_pkg::slot_idx_t m_idx,
	output ht_pkg::bucket_t m_bucket
);
	import ht_pkg::*;

	logic [SLOTS-1:0] hit1;
	logic [SLOTS-1:0] hit2;
	logic [SLOTS-1:0] empty1;
	logic [SLOTS-1:0] empty2;
	logic sel_hit;
	logic sel_room;
	logic sel_second;
	slot_idx_t sel_idx;

	// lowest set slot wins
	function automatic slot_idx_t first_set(input logic [SLOTS-1:0] v);
		slot_idx_t idx;
		idx = '0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (v[i]) begin
				idx = slot_idx_t'(i);
			end
		end
		return idx;
	endfunction

	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			hit1[i] = rd_bucket1[i].key == iss_key;
			hit2[i] = rd_bucket2[i].key == iss_key;
			empty1[i] = rd_bucket1[i].key == '0;
			empty2[i] = rd_bucket2[i].key == '0;
		end
	end

	// ----------------------------------------------------------------------
	// hit in hash1, hit in hash2, empty in hash1, empty in hash2
	always_comb begin
		sel_hit = 1'b0;
		sel_room = 1'b0;
		sel_second = 1'b0;
		sel_idx = '0;
		if (|hit1) begin
			sel_hit = 1'b1;
			sel_idx = first_set(hit1);
		end else if (|hit2) begin
			sel_hit = 1'b1;
			sel_second = 1'b1;
			sel_idx = first_set(hit2);
		end else if (|empty1) begin
			sel_room = 1'b1;
			sel_idx = first_set(empty1);
		end else if (|empty2) begin
			sel_room = 1'b1;
			sel_second = 1'b1;
			sel_idx = first_set(empty2);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			m_valid <= 1'b0;
		end else if (adv) begin
			m_valid <= iss_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (adv && iss_valid) begin
			m_op <= iss_op;
			m_key <= iss_key;
			m_ptr <= iss_ptr;
			m_size <= iss_size;
			m_tag <= iss_tag;
			m_hit <= sel_hit;
			m_room <= sel_room;
			m_idx <= sel_idx;
			m_addr <= sel_second ? iss_hash2 : iss_hash1;
			m_bucket <= sel_second ? rd_bucket2 : rd_bucket1;
			match_hash1 <= iss_hash1;
			match_hash2 <= iss_hash2;
		end
	end

	assign match_busy = m_valid;

	// a key sits in at most one slot of its bucket pair
	a_key_unique: assert property (@(posedge clk) disable iff (rst_regd)
		iss_valid && iss_hash1 != iss_hash2 |-> $onehot0({hit1, hit2}));

endmodule

`default_nettype wire

//--- logic/ht_bucket_ram.sv
// bucket table with two registered read ports, one write port and written flags
`default_nettype none

module ht_bucket_ram (
	input wire clk,
	input wire rst_regd,
	input wire rd_en,
	input wire ht_pkg::bucket_addr_t rd_addr1,
	input wire ht_pkg::bucket_addr_t rd_addr2,
	input wire wr_en,
	input wire ht_pkg::bucket_addr_t wr_addr,
	input wire ht_pkg::bucket_t wr_bucket,
	output ht_pkg::bucket_t rd_bucket1,
	output ht_pkg::bucket_t rd_bucket2
);
	import ht_pkg::*;

	bucket_t mem [2**BUCKET_ADDR_W];
	logic [2**BUCKET_ADDR_W-1:0] written;

	// unwritten buckets read back as empty
	always_ff @(posedge clk) begin
		if (rst_regd) begin
			written <= '0;
		end else if (wr_en) begin
			written[wr_addr] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_bucket;
		end
	end

	// outputs hold while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_bucket1 <= written[rd_addr1] ? mem[rd_addr1] : '0;
			rd_bucket2 <= written[rd_addr2] ? mem[rd_addr2] : '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/ht_issue.sv
// request acceptance stage that stalls on bucket hazards and launches both bucket reads
`default_nettype none

module ht_issue (
	input wire clk,
	input wire rst_regd,
	input wire req_valid,
	input wire ht_pkg::opcode_t req_op,
	input wire ht_pkg::key_t req_key,
	input wire ht_pkg::bucket_addr_t req_hash1,
	input wire ht_pkg::bucket_addr_t req_hash2,
	input wire ht_pkg::ptr_t req_ptr,
	input wire ht_pkg::size_t req_size,
	input wire ht_pkg::tag_t req_tag,
	input wire adv,
	input wire match_busy,
	input wire ht_pkg::bucket_addr_t match_hash1,
	input wire ht_pkg::bucket_addr_t match_hash2,
	input wire upd_busy,
	input wire ht_pkg::bucket_addr_t upd_addr,
	output logic req_ready,
	output logic rd_en,
	output ht_pkg::bucket_addr_t rd_addr1,
	output ht_pkg::bucket_addr_t rd_addr2,
	output logic iss_valid,
	output ht_pkg::opcode_t iss_op,
	output ht_pkg::key_t iss_key,
	output ht_pkg::bucket_addr_t iss_hash1,
	output ht_pkg::bucket_addr_t iss_hash2,
	output ht_pkg::ptr_t iss_ptr,
	output ht_pkg::size_t iss_size,
	output ht_pkg::tag_t iss_tag
);
	import ht_pkg::*;

	logic started;
	logic hazard;
	logic accept;

	function automatic logic pair_overlap(input bucket_addr_t a1, a2, b1, b2);
		return (a1 == b1) || (a1 == b2) || (a2 == b1) || (a2 == b2);
	endfunction

	// any bucket still owed a write by a later stage blocks the read
	assign hazard = (iss_valid && pair_overlap(req_hash1, req_hash2, iss_hash1, iss_hash2))
		|| (match_busy && pair_overlap(req_hash1, req_hash2, match_hash1, match_hash2))
		|| (upd_busy && (req_hash1 == upd_addr || req_hash2 == upd_addr));

	assign req_ready = started && adv && !hazard;
	assign accept = req_valid && req_ready;

	assign rd_en = accept;
	assign rd_addr1 = req_hash1;
	assign rd_addr2 = req_hash2;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			started <= 1'b0;
			iss_valid <= 1'b0;
		end else begin
			started <= 1'b1;
			if (adv) begin
				iss_valid <= accept;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			iss_op <= req_op;
			iss_key <= req_key;
			iss_hash1 <= req_hash1;
			iss_hash2 <= req_hash2;
			iss_ptr <= req_ptr;
			iss_size <= req_size;
			iss_tag <= req_tag;
		end
	end

	// zero is the empty marker and can never be stored
	a_key_nonzero: assert property (@(posedge clk) disable iff (rst_regd)
		accept |-> req_key != '0);

endmodule

`default_nettype wire

//--- logic/ht_pkg.sv
// hash table package with table geometry, slot and bucket layout and queue payloads
`default_nettype none

package ht_pkg;

	// ----------------------------------------------------------------------
	// table geometry
	localparam int KEY_W = 64;
	localparam int PTR_W = 32;
	localparam int SIZE_W = 16;
	localparam int TAG_W = 16;
	localparam int SLOTS = 4;
	localparam int BUCKET_ADDR_W = 8;

	// queue depths
	localparam int RESP_DEPTH = 4;
	localparam int FREE_DEPTH = 4;

	// ----------------------------------------------------------------------
	typedef logic [KEY_W-1:0] key_t;
	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [SIZE_W-1:0] size_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [BUCKET_ADDR_W-1:0] bucket_addr_t;
	typedef logic [$clog2(SLOTS)-1:0] slot_idx_t;

	// key zero marks an empty slot
	typedef struct packed {
		key_t key;
		ptr_t ptr;
		size_t size;
	} slot_t;

	typedef slot_t [SLOTS-1:0] bucket_t;

	typedef enum logic [1:0] {
		OP_GET = 2'd0,
		OP_SETCUR = 2'd1,
		OP_DELCUR = 2'd2
	} opcode_t;

	typedef enum logic [2:0] {
		ST_HIT = 3'd0,
		ST_MISS = 3'd1,
		ST_STORED = 3'd2,
		ST_REPLACED = 3'd3,
		ST_FULL = 3'd4
	} status_t;

	typedef struct packed {
		tag_t tag;
		status_t status;
		ptr_t ptr;
		size_t size;
	} resp_t;

	typedef struct packed {
		ptr_t ptr;
		size_t size;
	} free_t;

endpackage

`default_nettype wire
